//--- logic/axi_line_pkg.sv
`default_nettype none

package axi_line_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = LINE_W / DATA_W;
    localparam int BEAT_W         = $clog2(WORDS_PER_LINE);
    localparam int STRB_W         = DATA_W / 8;
    localparam int ID_W           = 4;
    localparam int LEN_W          = 8;
    localparam int SIZE_W         = 3;
    localparam int RESP_W         = 2;

    localparam logic [ID_W-1:0]   MASTER_ID   = 4'd1;
    localparam logic [1:0]        BURST_FIXED = 2'b00;
    localparam logic [1:0]        BURST_INCR  = 2'b01;
    localparam logic [SIZE_W-1:0] SIZE_WORD   = 3'd2; // 4 bytes per beat.
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;

    localparam int MEM_WORDS   = 1024;
    localparam int IDX_W       = $clog2(MEM_WORDS);
    localparam int QUEUE_DEPTH = 4;
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);
    localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT_DRAIN,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic [1:0] {
        SLV_IDLE,
        SLV_WRITE_DATA,
        SLV_WRITE_RESP,
        SLV_READ_DATA
    } slv_state_e;

    // top two address bits select the cacheable region.
    function automatic logic is_cacheable(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: 2] == 2'b00;
    endfunction

endpackage

`default_nettype wire

//--- logic/write_queue.sv
`timescale 1ns/1ps
`default_nettype none

module write_queue (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              push_i,
    input  logic                              pop_i,
    input  logic [axi_line_pkg::ADDR_W-1:0]   addr_i,
    input  logic [axi_line_pkg::LINE_W-1:0]   line_i,
    output logic [axi_line_pkg::ADDR_W-1:0]   addr_o,
    output logic [axi_line_pkg::LINE_W-1:0]   line_o,
    output logic                              empty_o,
    output logic                              full_o
);
    import axi_line_pkg::*;

    logic [ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
    logic [LINE_W-1:0] line_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              push_ok;
    logic              pop_ok;

    assign full_o  = count_q == CNT_W'(QUEUE_DEPTH);
    assign empty_o = count_q == '0;
    assign push_ok = push_i && !full_o; // a push into a full queue is dropped.
    assign pop_ok  = pop_i && !empty_o;
    assign addr_o  = addr_mem[rd_ptr_q];
    assign line_o  = line_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            addr_mem[wr_ptr_q] <= addr_i;
            line_mem[wr_ptr_q] <= line_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              q_empty_i,
    input  logic [axi_line_pkg::ADDR_W-1:0]   q_addr_i,
    input  logic [axi_line_pkg::LINE_W-1:0]   q_line_i,
    output logic                              q_pop_o,
    output logic                              busy_o,
    output logic [axi_line_pkg::ID_W-1:0]     awid_o,
    output logic [axi_line_pkg::ADDR_W-1:0]   awaddr_o,
    output logic [axi_line_pkg::LEN_W-1:0]    awlen_o,
    output logic [axi_line_pkg::SIZE_W-1:0]   awsize_o,
    output logic [1:0]                        awburst_o,
    output logic                              awvalid_o,
    input  logic                              awready_i,
    output logic [axi_line_pkg::DATA_W-1:0]   wdata_o,
    output logic [axi_line_pkg::STRB_W-1:0]   wstrb_o,
    output logic                              wlast_o,
    output logic                              wvalid_o,
    input  logic                              wready_i,
    input  logic [axi_line_pkg::ID_W-1:0]     bid_i,
    input  logic [axi_line_pkg::RESP_W-1:0]   bresp_i,
    input  logic                              bvalid_i,
    output logic                              bready_o
);
    import axi_line_pkg::*;

    wr_state_e         state_q;
    logic [ADDR_W-1:0] addr_q;
    logic [LINE_W-1:0] line_q;
    logic [BEAT_W-1:0] beat_q;
    logic              cacheable;
    logic              resp_ok;

    assign cacheable = is_cacheable(addr_q);
    assign q_pop_o   = (state_q == WR_IDLE) && !q_empty_i;
    assign busy_o    = q_pop_o || (state_q != WR_IDLE); // keeps reads behind this write.

    assign awid_o    = MASTER_ID;
    assign awaddr_o  = addr_q;
    assign awlen_o   = cacheable ? LEN_W'(WORDS_PER_LINE - 1) : '0;
    assign awsize_o  = SIZE_WORD;
    assign awburst_o = cacheable ? BURST_INCR : BURST_FIXED;
    assign awvalid_o = state_q == WR_ADDR;

    assign wdata_o   = line_q[beat_q*DATA_W +: DATA_W]; // word k on beat k.
    assign wstrb_o   = '1;
    assign wvalid_o  = state_q == WR_DATA;
    assign wlast_o   = wvalid_o && (LEN_W'(beat_q) == awlen_o);

    assign bready_o  = state_q == WR_RESP;
    assign resp_ok   = (bresp_i == RESP_OKAY) && (bid_i == MASTER_ID);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (q_pop_o) begin
                        state_q <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    beat_q <= '0;
                    if (awready_i) begin
                        state_q <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wready_i) begin
                        beat_q <= beat_q + BEAT_W'(1);
                        if (wlast_o) begin
                            state_q <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (bvalid_i) begin
                        state_q <= resp_ok ? WR_IDLE : WR_ADDR; // replay on a bad response.
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (q_pop_o) begin
            addr_q <= q_addr_i;
            line_q <= q_line_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              req_i,
    input  logic [axi_line_pkg::ADDR_W-1:0]   addr_i,
    input  logic                              q_empty_i,
    input  logic                              wr_busy_i,
    output logic [axi_line_pkg::ID_W-1:0]     arid_o,
    output logic [axi_line_pkg::ADDR_W-1:0]   araddr_o,
    output logic [axi_line_pkg::LEN_W-1:0]    arlen_o,
    output logic [axi_line_pkg::SIZE_W-1:0]   arsize_o,
    output logic [1:0]                        arburst_o,
    output logic                              arvalid_o,
    input  logic                              arready_i,
    input  logic [axi_line_pkg::ID_W-1:0]     rid_i,
    input  logic [axi_line_pkg::DATA_W-1:0]   rdata_i,
    input  logic [axi_line_pkg::RESP_W-1:0]   rresp_i,
    input  logic                              rlast_i,
    input  logic                              rvalid_i,
    output logic                              rready_o,
    output logic [axi_line_pkg::LINE_W-1:0]   line_o,
    output logic                              line_valid_o
);
    import axi_line_pkg::*;

    rd_state_e         state_q;
    logic [ADDR_W-1:0] addr_q;
    logic [LINE_W-1:0] asm_q;
    logic [LINE_W-1:0] merged;
    logic [BEAT_W-1:0] beat_q;
    logic [DATA_W-1:0] word_in;
    logic              cacheable;
    logic              last_beat;

    assign cacheable = is_cacheable(addr_q);
    assign arid_o    = MASTER_ID;
    assign araddr_o  = addr_q;
    assign arlen_o   = cacheable ? LEN_W'(WORDS_PER_LINE - 1) : '0;
    assign arsize_o  = SIZE_WORD;
    assign arburst_o = cacheable ? BURST_INCR : BURST_FIXED;
    assign arvalid_o = state_q == RD_ADDR;
    assign rready_o  = state_q == RD_DATA;
    assign last_beat = rready_o && rvalid_i && rlast_i;

    // a beat that is not ours or not OKAY contributes zeros.
    assign word_in = ((rid_i == MASTER_ID) && (rresp_i == RESP_OKAY)) ? rdata_i : '0;

    always_comb begin
        merged = asm_q;
        merged[beat_q*DATA_W +: DATA_W] = word_in;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q      <= RD_IDLE;
            beat_q       <= '0;
            line_o       <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat; // pulse the cycle after the last beat.
            if (last_beat) begin
                line_o <= merged;
            end
            case (state_q)
                RD_IDLE: begin
                    if (req_i) begin
                        state_q <= RD_WAIT_DRAIN;
                    end
                end
                RD_WAIT_DRAIN: begin
                    if (q_empty_i && !wr_busy_i) begin
                        state_q <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    beat_q <= '0;
                    if (arready_i) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rvalid_i) begin
                        beat_q <= beat_q + BEAT_W'(1);
                        if (rlast_i) begin
                            state_q <= RD_IDLE;
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == RD_IDLE) && req_i) begin
            addr_q <= addr_i;
        end
        if (state_q == RD_ADDR) begin
            asm_q <= '0; // uncached reads leave words 1 to 3 zero.
        end else if (rready_o && rvalid_i) begin
            asm_q <= merged;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_slave (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic [axi_line_pkg::ID_W-1:0]     awid_i,
    input  logic [axi_line_pkg::ADDR_W-1:0]   awaddr_i,
    input  logic [axi_line_pkg::LEN_W-1:0]    awlen_i,
    input  logic [axi_line_pkg::SIZE_W-1:0]   awsize_i,
    input  logic [1:0]                        awburst_i,
    input  logic                              awvalid_i,
    output logic                              awready_o,
    input  logic [axi_line_pkg::DATA_W-1:0]   wdata_i,
    input  logic [axi_line_pkg::STRB_W-1:0]   wstrb_i,
    input  logic                              wlast_i,
    input  logic                              wvalid_i,
    output logic                              wready_o,
    output logic [axi_line_pkg::ID_W-1:0]     bid_o,
    output logic [axi_line_pkg::RESP_W-1:0]   bresp_o,
    output logic                              bvalid_o,
    input  logic                              bready_i,
    input  logic [axi_line_pkg::ID_W-1:0]     arid_i,
    input  logic [axi_line_pkg::ADDR_W-1:0]   araddr_i,
    input  logic [axi_line_pkg::LEN_W-1:0]    arlen_i,
    input  logic [axi_line_pkg::SIZE_W-1:0]   arsize_i,
    input  logic [1:0]                        arburst_i,
    input  logic                              arvalid_i,
    output logic                              arready_o,
    output logic [axi_line_pkg::ID_W-1:0]     rid_o,
    output logic [axi_line_pkg::DATA_W-1:0]   rdata_o,
    output logic [axi_line_pkg::RESP_W-1:0]   rresp_o,
    output logic                              rlast_o,
    output logic                              rvalid_o,
    input  logic                              rready_i
);
    import axi_line_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    slv_state_e        state_q;
    logic [ADDR_W-1:0] cur_addr_q;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  beat_q;
    logic [SIZE_W-1:0] size_q;
    logic [1:0]        burst_q;
    logic [ID_W-1:0]   id_q;
    logic [IDX_W-1:0]  idx;
    logic              aw_take;
    logic              ar_take;
    logic              w_beat;
    logic              r_beat;

    assign idx     = cur_addr_q[IDX_W+1:2]; // both regions alias onto one array.
    assign aw_take = awvalid_i && awready_o;
    assign ar_take = arvalid_i && arready_o;
    assign w_beat  = wvalid_i && wready_o;
    assign r_beat  = rvalid_o && rready_i;

    assign wready_o = state_q == SLV_WRITE_DATA;
    assign bvalid_o = state_q == SLV_WRITE_RESP;
    assign bid_o    = id_q;
    assign bresp_o  = RESP_OKAY;
    assign rvalid_o = state_q == SLV_READ_DATA;
    assign rid_o    = id_q;
    assign rdata_o  = mem[idx];
    assign rresp_o  = RESP_OKAY;
    assign rlast_o  = rvalid_o && (beat_q == len_q);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q   <= SLV_IDLE;
            awready_o <= 1'b0;
            arready_o <= 1'b0;
        end else begin
            awready_o <= 1'b0;
            arready_o <= 1'b0;
            case (state_q)
                SLV_IDLE: begin
                    if (aw_take) begin
                        state_q <= SLV_WRITE_DATA;
                    end else if (ar_take) begin
                        state_q <= SLV_READ_DATA;
                    end else if (awvalid_i) begin
                        awready_o <= 1'b1; // writes win when both are pending.
                    end else if (arvalid_i) begin
                        arready_o <= 1'b1;
                    end
                end
                SLV_WRITE_DATA: begin
                    if (w_beat && wlast_i) begin
                        state_q <= SLV_WRITE_RESP;
                    end
                end
                SLV_WRITE_RESP: begin
                    if (bready_i) begin
                        state_q <= SLV_IDLE;
                    end
                end
                SLV_READ_DATA: begin
                    if (r_beat && rlast_o) begin
                        state_q <= SLV_IDLE;
                    end
                end
                default: state_q <= SLV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_take) begin
            cur_addr_q <= awaddr_i;
            len_q      <= awlen_i;
            size_q     <= awsize_i;
            burst_q    <= awburst_i;
            id_q       <= awid_i;
            beat_q     <= '0;
        end else if (ar_take) begin
            cur_addr_q <= araddr_i;
            len_q      <= arlen_i;
            size_q     <= arsize_i;
            burst_q    <= arburst_i;
            id_q       <= arid_i;
            beat_q     <= '0;
        end else if (w_beat || r_beat) begin
            beat_q <= beat_q + LEN_W'(1);
            if (burst_q == BURST_INCR) begin
                cur_addr_q <= cur_addr_q + (ADDR_W'(1) << size_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_beat) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_i[b]) begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_line_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module axi_line_subsystem (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              cs_i,
    input  logic                              we_i,
    input  logic [axi_line_pkg::ADDR_W-1:0]   addr_i,
    input  logic [axi_line_pkg::LINE_W-1:0]   wdata_i,
    output logic [axi_line_pkg::LINE_W-1:0]   rdata_o,
    output logic                              rvalid_o,
    output logic                              wq_full_o
);
    import axi_line_pkg::*;

    logic              q_empty;
    logic              q_full;
    logic [ADDR_W-1:0] q_addr;
    logic [LINE_W-1:0] q_line;
    logic              q_pop;
    logic              wr_busy;

    logic [ID_W-1:0]   awid;
    logic [ADDR_W-1:0] awaddr;
    logic [LEN_W-1:0]  awlen;
    logic [SIZE_W-1:0] awsize;
    logic [1:0]        awburst;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    logic [ID_W-1:0]   bid;
    logic [RESP_W-1:0] bresp;
    logic              bvalid;
    logic              bready;
    logic [ID_W-1:0]   arid;
    logic [ADDR_W-1:0] araddr;
    logic [LEN_W-1:0]  arlen;
    logic [SIZE_W-1:0] arsize;
    logic [1:0]        arburst;
    logic              arvalid;
    logic              arready;
    logic [ID_W-1:0]   rid;
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] rresp;
    logic              rlast;
    logic              rvalid;
    logic              rready;

    assign wq_full_o = q_full;

    write_queue i_write_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (cs_i && we_i),
        .pop_i   (q_pop),
        .addr_i  (addr_i),
        .line_i  (wdata_i),
        .addr_o  (q_addr),
        .line_o  (q_line),
        .empty_o (q_empty),
        .full_o  (q_full)
    );

    axi_write_engine i_axi_write_engine (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .q_empty_i (q_empty),
        .q_addr_i  (q_addr),
        .q_line_i  (q_line),
        .q_pop_o   (q_pop),
        .busy_o    (wr_busy),
        .awid_o    (awid),
        .awaddr_o  (awaddr),
        .awlen_o   (awlen),
        .awsize_o  (awsize),
        .awburst_o (awburst),
        .awvalid_o (awvalid),
        .awready_i (awready),
        .wdata_o   (wdata),
        .wstrb_o   (wstrb),
        .wlast_o   (wlast),
        .wvalid_o  (wvalid),
        .wready_i  (wready),
        .bid_i     (bid),
        .bresp_i   (bresp),
        .bvalid_i  (bvalid),
        .bready_o  (bready)
    );

    axi_read_engine i_axi_read_engine (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (cs_i && !we_i),
        .addr_i       (addr_i),
        .q_empty_i    (q_empty),
        .wr_busy_i    (wr_busy),
        .arid_o       (arid),
        .araddr_o     (araddr),
        .arlen_o      (arlen),
        .arsize_o     (arsize),
        .arburst_o    (arburst),
        .arvalid_o    (arvalid),
        .arready_i    (arready),
        .rid_i        (rid),
        .rdata_i      (rdata),
        .rresp_i      (rresp),
        .rlast_i      (rlast),
        .rvalid_i     (rvalid),
        .rready_o     (rready),
        .line_o       (rdata_o),
        .line_valid_o (rvalid_o)
    );

    axi_mem_slave i_axi_mem_slave (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .awid_i    (awid),
        .awaddr_i  (awaddr),
        .awlen_i   (awlen),
        .awsize_i  (awsize),
        .awburst_i (awburst),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wlast_i   (wlast),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bid_o     (bid),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .arid_i    (arid),
        .araddr_i  (araddr),
        .arlen_i   (arlen),
        .arsize_i  (arsize),
        .arburst_i (arburst),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rid_o     (rid),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rlast_o   (rlast),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

endmodule

`default_nettype wire

//--- tests/axi_line_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_line_tb;
    import axi_line_pkg::*;

    localparam int          MAX_OPS       = 64;
    localparam int          RESET_CYCLES  = 8;
    localparam int          CYCLES_PER_OP = 60;
    localparam logic [15:0] LFSR_SEED     = 16'd45604;

    typedef enum logic [7:0] {
        OP_END   = 8'h00,
        OP_WRITE = 8'h01,
        OP_READ  = 8'h02,
        OP_FILL  = 8'h03,
        OP_SWEEP = 8'h04,
        OP_FULL  = 8'h05
    } op_e;

    logic              clk_i;
    logic              rst_ni;
    logic              cs_i;
    logic              we_i;
    logic [ADDR_W-1:0] addr_i;
    logic [LINE_W-1:0] wdata_i;
    logic [LINE_W-1:0] rdata_o;
    logic              rvalid_o;
    logic              wq_full_o;

    logic [LINE_W-1:0] pat_mem [4*MAX_OPS]; // four words per operation.
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    logic [LINE_W-1:0] last_rdata      = '0;
    logic [15:0]       lfsr_state      = LFSR_SEED;
    logic              full_seen       = 1'b0;
    logic              watchdog_armed  = 1'b0;
    int                watchdog_cycles = 0;
    int                reads_done      = 0;
    int                pulse_count     = 0;

    axi_line_subsystem i_axi_line_subsystem (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .cs_i      (cs_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .rdata_o   (rdata_o),
        .rvalid_o  (rvalid_o),
        .wq_full_o (wq_full_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] expected,
                               input logic [LINE_W-1:0] actual);
        assert (actual === expected) else begin
            abort_run($sformatf("Error at %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_line(output logic [LINE_W-1:0] line);
        for (int b = 0; b < LINE_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            line[b]    = lfsr_state[0];
        end
    endtask

    function automatic logic in_cached_region(input logic [ADDR_W-1:0] addr);
        return addr[31:30] == 2'b00;
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
        logic [IDX_W-1:0] idx;
        idx = addr[IDX_W+1:2]; // all regions share one word array.
        if (in_cached_region(addr)) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                model_mem[idx + IDX_W'(k)] = line[DATA_W*k +: DATA_W];
            end
        end else begin
            model_mem[idx] = line[DATA_W-1:0]; // single beat carries word 0.
        end
    endtask

    function automatic logic [LINE_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        logic [IDX_W-1:0]  idx;
        line = '0;
        idx  = addr[IDX_W+1:2];
        if (in_cached_region(addr)) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                line[DATA_W*k +: DATA_W] = model_mem[idx + IDX_W'(k)];
            end
        end else begin
            line[DATA_W-1:0] = model_mem[idx];
        end
        return line;
    endfunction

    task automatic write_line(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
        @(negedge clk_i);
        while (wq_full_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        cs_i    <= 1'b1;
        we_i    <= 1'b1;
        addr_i  <= addr;
        wdata_i <= line;
        @(posedge clk_i);
        cs_i    <= 1'b0;
        we_i    <= 1'b0;
        model_write(addr, line);
    endtask

    task automatic read_line(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] expected);
        @(posedge clk_i);
        cs_i   <= 1'b1;
        we_i   <= 1'b0;
        addr_i <= addr;
        @(posedge clk_i);
        cs_i   <= 1'b0;
        @(negedge clk_i);
        while (!rvalid_o) begin
            check_value("rdata_o", last_rdata, rdata_o); // old line holds meanwhile.
            @(negedge clk_i);
        end
        check_value("rdata_o", expected, rdata_o);
        last_rdata = expected;
        reads_done++;
        @(negedge clk_i);
        check_value("rvalid_o", '0, LINE_W'(rvalid_o));
    endtask

    task automatic fill_lines(input logic [ADDR_W-1:0] base, input int count);
        logic [LINE_W-1:0] line;
        for (int i = 0; i < count; i++) begin
            random_line(line);
            write_line(base + ADDR_W'(16 * i), line);
        end
    endtask

    // visits the lines in a stride order, stride odd so all are hit.
    task automatic sweep_lines(input logic [ADDR_W-1:0] base, input int count, input int stride);
        logic [ADDR_W-1:0] addr;
        int                j;
        for (int i = 0; i < count; i++) begin
            j    = (i * stride) % count;
            addr = base + ADDR_W'(16 * j);
            read_line(addr, model_read(addr));
        end
    endtask

    always @(negedge clk_i) begin
        if (rst_ni && rvalid_o) begin
            pulse_count <= pulse_count + 1;
        end
        if (wq_full_o) begin
            full_seen <= 1'b1;
        end
    end

    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge clk_i);
        abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                            watchdog_cycles));
    end

    initial begin
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] line;
        logic [LINE_W-1:0] expected;
        int                n_ops;
        int                weight;

        $timeformat(-9, 0, " ns", 0);
        rst_ni  <= 1'b0;
        cs_i    <= 1'b0;
        we_i    <= 1'b0;
        addr_i  <= '0;
        wdata_i <= '0;
        $readmemh("tests/axi_line_patterns.mem", pat_mem);

        n_ops  = 0;
        weight = 0;
        while (n_ops < MAX_OPS && pat_mem[4*n_ops] !== LINE_W'(OP_END)) begin
            op = op_e'(pat_mem[4*n_ops][7:0]);
            if (op == OP_FILL || op == OP_SWEEP) begin
                weight += int'(pat_mem[4*n_ops+2][7:0]); // one budget per line.
            end else begin
                weight += 1;
            end
            n_ops++;
        end
        assert (n_ops < MAX_OPS) else abort_run("the pattern file has no end entry");
        watchdog_cycles = CYCLES_PER_OP * weight + RESET_CYCLES + 20;
        watchdog_armed  = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            check_value("rvalid_o", '0, LINE_W'(rvalid_o));
            check_value("rdata_o", '0, rdata_o);
        end

        for (int i = 0; i < n_ops; i++) begin
            op       = op_e'(pat_mem[4*i][7:0]);
            addr     = pat_mem[4*i+1][ADDR_W-1:0];
            line     = pat_mem[4*i+2];
            expected = pat_mem[4*i+3];
            case (op)
                OP_WRITE: write_line(addr, line);
                OP_READ:  read_line(addr, expected);
                OP_FILL:  fill_lines(addr, int'(line[7:0]));
                OP_SWEEP: sweep_lines(addr, int'(line[7:0]), int'(line[15:8]));
                OP_FULL: begin
                    repeat (2) @(negedge clk_i);
                    assert (full_seen) else begin
                        abort_run("wq_full_o never went high while the queue was filled");
                    end
                end
                default: begin
                    abort_run($sformatf("unknown opcode %h in pattern entry %0d",
                                        pat_mem[4*i][7:0], i));
                end
            endcase
        end

        repeat (2) @(negedge clk_i);
        assert (pulse_count == reads_done) else begin
            abort_run($sformatf("Error at %0t: rvalid_o pulses expected %0d, actual %0d",
                                $time, reads_done, pulse_count));
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/axi_line_patterns.mem
// columns: opcode address line expected; opcodes 01 write, 02 read, 03 fill, 04 sweep, 05 full, 00 end
// fill and sweep take the line count in line bits 7:0 and the sweep stride in bits 15:8
01 00000100 0123456789abcdeffedcba9876543210 00000000000000000000000000000000
02 00000100 00000000000000000000000000000000 0123456789abcdeffedcba9876543210
01 80000300 11111111222222223333333344444444 00000000000000000000000000000000
02 80000300 00000000000000000000000000000000 00000000000000000000000044444444
02 c0000300 00000000000000000000000000000000 00000000000000000000000044444444
01 00000040 a0a0a0a0b1b1b1b1c2c2c2c2d3d3d3d3 00000000000000000000000000000000
01 40000040 eeeeeeeeffffffff99999999cafef00d 00000000000000000000000000000000
02 00000040 00000000000000000000000000000000 a0a0a0a0b1b1b1b1c2c2c2c2cafef00d
02 40000040 00000000000000000000000000000000 000000000000000000000000cafef00d
01 00000200 00000001000000020000000300000004 00000000000000000000000000000000
01 00000200 10000001100000021000000310000004 00000000000000000000000000000000
01 00000200 20000001200000022000000320000004 00000000000000000000000000000000
01 00000200 30000001300000023000000330000004 00000000000000000000000000000000
01 00000200 40000001400000024000000340000004 00000000000000000000000000000000
05 00000000 00000000000000000000000000000000 00000000000000000000000000000000
02 00000200 00000000000000000000000000000000 40000001400000024000000340000004
03 00000400 00000000000000000000000000000020 00000000000000000000000000000000
04 00000400 00000000000000000000000000000720 00000000000000000000000000000000
03 00000800 00000000000000000000000000000008 00000000000000000000000000000000
04 00000800 00000000000000000000000000000308 00000000000000000000000000000000
02 00000100 00000000000000000000000000000000 0123456789abcdeffedcba9876543210
02 00000040 00000000000000000000000000000000 a0a0a0a0b1b1b1b1c2c2c2c2cafef00d
00 00000000 00000000000000000000000000000000 00000000000000000000000000000000

//--- files.f
logic/axi_line_pkg.sv
logic/write_queue.sv
logic/axi_write_engine.sv
logic/axi_read_engine.sv
logic/axi_mem_slave.sv
logic/axi_line_subsystem.sv
tests/axi_line_tb.sv
